// ==== hdl/i2c_target_pkg.sv ====
// Widths, register map constants, bus address and protocol states shared by the I2C target
package i2c_target_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  page_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [15:0] version_word_t;
    typedef logic [2:0]  version_index_t;
    typedef logic [3:0]  bit_count_t;

    // 7-bit address this target answers on the bus
    localparam logic [6:0] target_address = 7'h48;

    localparam page_t page_version = 8'h00;
    localparam page_t page_config  = 8'h01;

    localparam reg_addr_t reg_brightness   = 8'h00;
    localparam reg_addr_t reg_contrast     = 8'h01;
    // Reads on the version page wrap here
    localparam reg_addr_t version_last_reg = 8'h0F;

    localparam byte_t brightness_default = 8'h80;
    localparam byte_t contrast_default   = 8'h40;
    localparam byte_t unmapped_data      = 8'hFF;

    // Byte-level protocol states
    typedef enum logic [3:0] {
        idle,
        start_seen,
        address,
        address_ack,
        write_data,
        write_ack,
        read_data,
        read_ack,
        wait_idle
    } state_t;

endpackage

// ==== hdl/regmap_if.sv ====
// Register pointer, write strobe and read data passed from the protocol engine to the register map
`timescale 1ns/1ns

interface regmap_if;

    // Current page and register pointer
    i2c_target_pkg::page_t     page;
    i2c_target_pkg::reg_addr_t reg_addr;

    // One-cycle write of wr_data to page/reg_addr
    logic                      wr_strobe;
    i2c_target_pkg::byte_t     wr_data;

    // Combinational read data for the current pointer
    i2c_target_pkg::byte_t     rd_data;

    modport engine (
        output page,
        output reg_addr,
        output wr_strobe,
        output wr_data,
        input  rd_data
    );

    modport regmap (
        input  page,
        input  reg_addr,
        input  wr_strobe,
        input  wr_data,
        output rd_data
    );

endinterface

// ==== hdl/bus_conditioner.sv ====
// Synchronizes SCL and SDA and turns them into filtered edge, START and STOP pulses
`timescale 1ns/1ns

module bus_conditioner (
    input  logic clk,
    input  logic rst_n,
    input  logic scl,
    input  logic sda,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic sda_level
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_clean;
    logic       sda_clean;
    logic       scl_d1;
    logic       scl_d2;
    logic       sda_d1;
    logic       sda_d2;
    logic       scl_stable_high;

    // Two-flop synchronizers plus two history samples per line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_d1   <= 1'b1;
            scl_d2   <= 1'b1;
            sda_d1   <= 1'b1;
            sda_d2   <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
            scl_d1   <= scl_clean;
            scl_d2   <= scl_d1;
            sda_d1   <= sda_clean;
            sda_d2   <= sda_d1;
        end
    end

    assign scl_clean = scl_sync[1];
    assign sda_clean = sda_sync[1];

    // An edge counts once the new level has held for two samples
    assign scl_rise = scl_clean & scl_d1 & ~scl_d2;
    assign scl_fall = ~scl_clean & ~scl_d1 & scl_d2;

    assign scl_stable_high = scl_clean & scl_d1 & scl_d2;

    // SDA moving while SCL is held high marks START or STOP
    assign start_seen = ~sda_clean & ~sda_d1 & sda_d2 & scl_stable_high;
    assign stop_seen  = sda_clean & sda_d1 & ~sda_d2 & scl_stable_high;

    assign sda_level = sda_clean;

endmodule

// ==== hdl/i2c_protocol_fsm.sv ====
// Byte-level I2C target engine: address match, pointer handling, ACKs and the SDA drive
`timescale 1ns/1ns

module i2c_protocol_fsm (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     scl_rise,
    input  logic     scl_fall,
    input  logic     start_seen,
    input  logic     stop_seen,
    input  logic     sda_level,
    regmap_if.engine regmap,
    output logic     sda_oe,
    output logic     sda_low_bit
);

    i2c_target_pkg::state_t     state;
    i2c_target_pkg::bit_count_t bit_cnt;
    i2c_target_pkg::byte_t      shift_reg;
    i2c_target_pkg::page_t      page;
    i2c_target_pkg::reg_addr_t  reg_addr;
    i2c_target_pkg::reg_addr_t  read_next;
    i2c_target_pkg::byte_t      wr_data;
    logic                       wr_strobe;
    logic [1:0]                 write_count;
    logic                       master_ack;
    logic                       addr_match;

    assign regmap.page      = page;
    assign regmap.reg_addr  = reg_addr;
    assign regmap.wr_strobe = wr_strobe;
    assign regmap.wr_data   = wr_data;

    assign addr_match = (shift_reg[7:1] == i2c_target_pkg::target_address);

    // Next register for a read, the version page wraps after its last byte
    assign read_next = (page == i2c_target_pkg::page_version &&
                        reg_addr == i2c_target_pkg::version_last_reg) ? 8'h00 : reg_addr + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= i2c_target_pkg::idle;
            bit_cnt     <= '0;
            shift_reg   <= '0;
            page        <= i2c_target_pkg::page_version;
            reg_addr    <= '0;
            wr_data     <= '0;
            wr_strobe   <= 1'b0;
            write_count <= '0;
            master_ack  <= 1'b0;
            sda_oe      <= 1'b0;
            sda_low_bit <= 1'b1;
        end else begin
            wr_strobe <= 1'b0;

            // Register map takes the byte on this edge, move on to the next register
            if (wr_strobe) begin
                reg_addr <= reg_addr + 8'd1;
            end

            if (stop_seen) begin
                state       <= i2c_target_pkg::wait_idle;
                bit_cnt     <= '0;
                write_count <= '0;
                sda_oe      <= 1'b0;
            end else if (start_seen) begin
                // Repeated start keeps pointer and byte count
                state   <= i2c_target_pkg::start_seen;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end else begin
                case (state)
                    i2c_target_pkg::idle: begin
                        bit_cnt <= '0;
                    end

                    i2c_target_pkg::start_seen: begin
                        state <= i2c_target_pkg::address;
                    end

                    i2c_target_pkg::address: begin
                        if (scl_rise) begin
                            shift_reg <= {shift_reg[6:0], sda_level};
                            bit_cnt   <= bit_cnt + 4'd1;
                        end else if (scl_fall && bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            if (addr_match) begin
                                state       <= i2c_target_pkg::address_ack;
                                sda_oe      <= 1'b1;
                                sda_low_bit <= 1'b0;
                            end else begin
                                // Not ours, leave SDA released (NACK)
                                state <= i2c_target_pkg::wait_idle;
                            end
                        end
                    end

                    i2c_target_pkg::address_ack: begin
                        if (scl_fall) begin
                            if (shift_reg[0]) begin
                                // Read: first byte goes out right away
                                state       <= i2c_target_pkg::read_data;
                                shift_reg   <= regmap.rd_data;
                                sda_low_bit <= regmap.rd_data[7];
                            end else begin
                                state  <= i2c_target_pkg::write_data;
                                sda_oe <= 1'b0;
                            end
                        end
                    end

                    i2c_target_pkg::write_data: begin
                        if (scl_rise) begin
                            shift_reg <= {shift_reg[6:0], sda_level};
                            bit_cnt   <= bit_cnt + 4'd1;
                        end else if (scl_fall && bit_cnt == 4'd8) begin
                            state       <= i2c_target_pkg::write_ack;
                            bit_cnt     <= '0;
                            sda_oe      <= 1'b1;
                            sda_low_bit <= 1'b0;
                        end
                    end

                    i2c_target_pkg::write_ack: begin
                        if (scl_fall) begin
                            state  <= i2c_target_pkg::write_data;
                            sda_oe <= 1'b0;
                            case (write_count)
                                2'd0: begin
                                    // Single byte selects a version register
                                    page        <= i2c_target_pkg::page_version;
                                    reg_addr    <= shift_reg;
                                    write_count <= 2'd1;
                                end
                                2'd1: begin
                                    // First byte was the page
                                    page        <= reg_addr;
                                    reg_addr    <= shift_reg;
                                    write_count <= 2'd2;
                                end
                                default: begin
                                    wr_strobe <= 1'b1;
                                    wr_data   <= shift_reg;
                                end
                            endcase
                        end
                    end

                    i2c_target_pkg::read_data: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (scl_fall) begin
                            if (bit_cnt == 4'd8) begin
                                // Hand SDA to the controller for its ACK
                                state   <= i2c_target_pkg::read_ack;
                                bit_cnt <= '0;
                                sda_oe  <= 1'b0;
                            end else if (bit_cnt != 4'd0) begin
                                sda_low_bit <= shift_reg[6];
                                shift_reg   <= {shift_reg[6:0], 1'b1};
                            end
                        end
                    end

                    i2c_target_pkg::read_ack: begin
                        if (scl_rise) begin
                            master_ack <= ~sda_level;
                            // Advance now so rd_data is settled by the SCL fall
                            if (!sda_level) begin
                                reg_addr <= read_next;
                            end
                        end else if (scl_fall) begin
                            if (master_ack) begin
                                state       <= i2c_target_pkg::read_data;
                                shift_reg   <= regmap.rd_data;
                                sda_oe      <= 1'b1;
                                sda_low_bit <= regmap.rd_data[7];
                            end else begin
                                state <= i2c_target_pkg::wait_idle;
                            end
                        end
                    end

                    i2c_target_pkg::wait_idle: begin
                        state <= i2c_target_pkg::idle;
                    end

                    default: begin
                        state  <= i2c_target_pkg::idle;
                        sda_oe <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/register_map.sv ====
// Configuration registers and read data selection between the version port and config page
`timescale 1ns/1ns

module register_map (
    input  logic                           clk,
    input  logic                           rst_n,
    regmap_if.regmap                       regmap,
    output i2c_target_pkg::version_index_t version_addr,
    input  i2c_target_pkg::version_word_t  version_data,
    output i2c_target_pkg::byte_t          brightness,
    output i2c_target_pkg::byte_t          contrast
);

    logic config_write;
    logic version_hit;

    // Writes land only on the configuration page
    assign config_write = regmap.wr_strobe && (regmap.page == i2c_target_pkg::page_config);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brightness <= i2c_target_pkg::brightness_default;
            contrast   <= i2c_target_pkg::contrast_default;
        end else if (config_write) begin
            case (regmap.reg_addr)
                i2c_target_pkg::reg_brightness: begin
                    brightness <= regmap.wr_data;
                end
                i2c_target_pkg::reg_contrast: begin
                    contrast <= regmap.wr_data;
                end
                default: begin
                    brightness <= brightness;
                end
            endcase
        end
    end

    // Two register numbers per version word
    assign version_addr = regmap.reg_addr[3:1];

    assign version_hit = (regmap.page == i2c_target_pkg::page_version) &&
                         (regmap.reg_addr <= i2c_target_pkg::version_last_reg);

    always_comb begin
        regmap.rd_data = i2c_target_pkg::unmapped_data;
        if (version_hit) begin
            // Even register is the high byte
            if (regmap.reg_addr[0]) begin
                regmap.rd_data = version_data[7:0];
            end else begin
                regmap.rd_data = version_data[15:8];
            end
        end else if (regmap.page == i2c_target_pkg::page_config) begin
            case (regmap.reg_addr)
                i2c_target_pkg::reg_brightness: begin
                    regmap.rd_data = brightness;
                end
                i2c_target_pkg::reg_contrast: begin
                    regmap.rd_data = contrast;
                end
                default: begin
                    regmap.rd_data = i2c_target_pkg::unmapped_data;
                end
            endcase
        end
    end

endmodule

// ==== hdl/version_i2c_target.sv ====
// Top level of the I2C version target, ties the engine to the pins and the register map
`timescale 1ns/1ns

module version_i2c_target (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           scl,
    inout  wire                            sda,
    output i2c_target_pkg::version_index_t version_addr,
    input  i2c_target_pkg::version_word_t  version_data,
    output i2c_target_pkg::byte_t          brightness,
    output i2c_target_pkg::byte_t          contrast
);

    logic scl_rise;
    logic scl_fall;
    logic start_seen;
    logic stop_seen;
    logic sda_level;
    logic sda_oe;
    logic sda_low_bit;

    regmap_if regmap_bus ();

    bus_conditioner u_conditioner (
        .clk        (clk),
        .rst_n      (rst_n),
        .scl        (scl),
        .sda        (sda),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .sda_level  (sda_level)
    );

    i2c_protocol_fsm u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl_rise    (scl_rise),
        .scl_fall    (scl_fall),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .sda_level   (sda_level),
        .regmap      (regmap_bus.engine),
        .sda_oe      (sda_oe),
        .sda_low_bit (sda_low_bit)
    );

    register_map u_regmap (
        .clk          (clk),
        .rst_n        (rst_n),
        .regmap       (regmap_bus.regmap),
        .version_addr (version_addr),
        .version_data (version_data),
        .brightness   (brightness),
        .contrast     (contrast)
    );

    // Open-drain pin, only ever pulled low
    assign sda = (sda_oe && !sda_low_bit) ? 1'b0 : 1'bz;

endmodule

// ==== sim/i2c_protocol_properties.sv ====
// Concurrent checks on the I2C protocol engine, attached to every i2c_protocol_fsm through bind
`timescale 1ns/1ns

module i2c_protocol_properties (
    input logic                   clk,
    input logic                   rst_n,
    input i2c_target_pkg::state_t state,
    input logic                   sda_oe,
    input logic                   wr_strobe,
    input logic                   stop_seen
);

    logic quiet_state;

    // States in which only the controller drives SDA
    assign quiet_state = (state == i2c_target_pkg::idle) ||
                         (state == i2c_target_pkg::address) ||
                         (state == i2c_target_pkg::write_data);

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_strobe |=> !wr_strobe
    ) else $error("wr_strobe stayed high for two consecutive cycles");

    released_in_quiet_state: assert property (
        @(posedge clk) disable iff (!rst_n)
        quiet_state |-> !sda_oe
    ) else $error("sda_oe high in idle, address or write_data state");

    // STOP hands the bus back at once
    released_after_stop: assert property (
        @(posedge clk) disable iff (!rst_n)
        stop_seen |=> !sda_oe
    ) else $error("sda_oe still high in the cycle after STOP");

endmodule

bind i2c_protocol_fsm i2c_protocol_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .sda_oe    (sda_oe),
    .wr_strobe (wr_strobe),
    .stop_seen (stop_seen)
);

// ==== sim/tb_version_i2c.sv ====
// Simulation top for the I2C version target with a bus controller model and version memory
`timescale 1ns/1ns

module tb_version_i2c;

    // Each SCL phase is two halves of this many clk cycles
    localparam int half_phase   = 12;
    localparam int free_timeout = 200;

    localparam logic [6:0] own_address      = 7'h48;
    localparam logic [6:0] other_address    = 7'h49;
    localparam logic [7:0] reset_brightness = 8'h80;
    localparam logic [7:0] reset_contrast   = 8'h40;
    localparam logic [7:0] empty_byte       = 8'hFF;

    logic        clk;
    logic        rst_n;
    logic        scl_pull;
    logic        sda_pull;
    logic        scl;
    wire         sda;
    logic [2:0]  version_addr;
    logic [15:0] version_data;
    logic [7:0]  brightness;
    logic [7:0]  contrast;

    logic [15:0] version_table [8];
    logic [7:0]  model_brightness;
    logic [7:0]  model_contrast;

    int    error_count;
    int    tests_run;
    int    tests_failed;
    int    test_start_errors;
    string test_name;

    // SCL has no other driver and reads high when released
    assign scl = scl_pull ? 1'b0 : 1'b1;

    // Open-drain SDA shared with the target
    assign sda = sda_pull ? 1'b0 : 1'bz;
    pullup (sda);

    // Version memory answers the word index at once
    assign version_data = version_table[version_addr];

    always #2 clk = ~clk;

    version_i2c_target dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .scl          (scl),
        .sda          (sda),
        .version_addr (version_addr),
        .version_data (version_data),
        .brightness   (brightness),
        .contrast     (contrast)
    );

    task automatic hold_cycles(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s got %0b expected %0b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_bus_free();
        int waited;
        waited = 0;
        while (sda !== 1'b1 && waited < free_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (sda !== 1'b1) begin
            $display("Timeout at %0t ns: target kept SDA low, no START possible", $time);
            error_count++;
        end
    endtask

    // One SCL clock that starts and ends with SCL low
    // SDA changes only in the low phase
    task automatic clock_bit(input logic tx_bit, output logic rx_bit);
        hold_cycles(half_phase);
        sda_pull = ~tx_bit;
        hold_cycles(half_phase);
        scl_pull = 1'b0;
        hold_cycles(half_phase);
        rx_bit = sda;
        hold_cycles(half_phase);
        scl_pull = 1'b1;
    endtask

    task automatic send_start();
        hold_cycles(half_phase);
        sda_pull = 1'b0;
        wait_bus_free();
        hold_cycles(half_phase);
        scl_pull = 1'b0;
        hold_cycles(2 * half_phase);
        sda_pull = 1'b1;
        hold_cycles(2 * half_phase);
        scl_pull = 1'b1;
    endtask

    task automatic send_stop();
        hold_cycles(half_phase);
        sda_pull = 1'b1;
        hold_cycles(half_phase);
        scl_pull = 1'b0;
        hold_cycles(2 * half_phase);
        sda_pull = 1'b0;
        hold_cycles(2 * half_phase);
    endtask

    // Returns the SDA level of the ninth clock (low for ACK)
    task automatic write_byte(input logic [7:0] data, output logic ack_level);
        logic echo;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(data[i], echo);
            // Target must leave SDA to the controller while data bits go out
            check_bit($sformatf("sda during write bit %0d", i), echo, data[i]);
        end
        clock_bit(1'b1, ack_level);
    endtask

    task automatic read_byte(input logic send_ack, output logic [7:0] data);
        logic rx;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b1, rx);
            data[i] = rx;
        end
        clock_bit(~send_ack, rx);
    endtask

    task automatic write_expect_ack(input logic [7:0] data, input logic exp_level,
                                    input string what);
        logic ack_level;
        write_byte(data, ack_level);
        check_bit($sformatf("sda at ACK of %s", what), ack_level, exp_level);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        int test_errors;
        test_errors = error_count - test_start_errors;
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_reset_values();
        start_test("reset_values");
        check_byte("brightness", brightness, reset_brightness);
        check_byte("contrast", contrast, reset_contrast);
        check_bit("sda", sda, 1'b1);
        finish_test();
    endtask

    // Every byte stays NACKed because none is addressed to the target
    task automatic reject_other_address();
        start_test("other_address");
        send_start();
        write_expect_ack({other_address, 1'b0}, 1'b1, "address 0x49");
        write_expect_ack(8'h01, 1'b1, "page byte");
        write_expect_ack(8'h00, 1'b1, "register byte");
        write_expect_ack(8'h3C, 1'b1, "data byte");
        send_stop();
        check_byte("brightness", brightness, model_brightness);
        check_byte("contrast", contrast, model_contrast);
        finish_test();
    endtask

    task automatic write_config_page();
        logic [7:0] first_data;
        logic [7:0] second_data;
        first_data  = 8'($urandom());
        second_data = 8'($urandom());
        start_test("config_write");
        send_start();
        write_expect_ack({own_address, 1'b0}, 1'b0, "address 0x48");
        write_expect_ack(8'h01, 1'b0, "page byte");
        write_expect_ack(8'h00, 1'b0, "register byte");
        write_expect_ack(first_data, 1'b0, "brightness data");
        write_expect_ack(second_data, 1'b0, "contrast data");
        send_stop();
        model_brightness = first_data;
        model_contrast   = second_data;
        check_byte("brightness", brightness, model_brightness);
        check_byte("contrast", contrast, model_contrast);
        // Page 0 is read-only
        send_start();
        write_expect_ack({own_address, 1'b0}, 1'b0, "address 0x48");
        write_expect_ack(8'h00, 1'b0, "page byte");
        write_expect_ack(8'h00, 1'b0, "register byte");
        write_expect_ack(~first_data, 1'b0, "page 0 data");
        send_stop();
        check_byte("brightness", brightness, model_brightness);
        check_byte("contrast", contrast, model_contrast);
        finish_test();
    endtask

    task automatic read_version_wrap();
        logic [7:0] got;
        start_test("version_read_wrap");
        send_start();
        write_expect_ack({own_address, 1'b0}, 1'b0, "address 0x48");
        write_expect_ack(8'h0E, 1'b0, "register byte");
        send_start();
        write_expect_ack({own_address, 1'b1}, 1'b0, "read address");
        read_byte(1'b1, got);
        check_byte("read data reg 0x0E", got, version_table[7][15:8]);
        read_byte(1'b1, got);
        check_byte("read data reg 0x0F", got, version_table[7][7:0]);
        // Register number wraps to 0x00 here
        read_byte(1'b1, got);
        check_byte("read data reg 0x00", got, version_table[0][15:8]);
        read_byte(1'b0, got);
        check_byte("read data reg 0x01", got, version_table[0][7:0]);
        send_stop();
        finish_test();
    endtask

    task automatic read_config_back();
        logic [7:0] got;
        start_test("config_readback");
        send_start();
        write_expect_ack({own_address, 1'b0}, 1'b0, "address 0x48");
        write_expect_ack(8'h01, 1'b0, "page byte");
        write_expect_ack(8'h00, 1'b0, "register byte");
        send_start();
        write_expect_ack({own_address, 1'b1}, 1'b0, "read address");
        read_byte(1'b1, got);
        check_byte("read data brightness", got, model_brightness);
        read_byte(1'b1, got);
        check_byte("read data contrast", got, model_contrast);
        read_byte(1'b0, got);
        check_byte("read data page 1 reg 2", got, empty_byte);
        send_stop();
        // Page 5 holds nothing
        send_start();
        write_expect_ack({own_address, 1'b0}, 1'b0, "address 0x48");
        write_expect_ack(8'h05, 1'b0, "page byte");
        write_expect_ack(8'h00, 1'b0, "register byte");
        send_start();
        write_expect_ack({own_address, 1'b1}, 1'b0, "read address");
        read_byte(1'b0, got);
        check_byte("read data page 5 reg 0", got, empty_byte);
        send_stop();
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        scl_pull     = 1'b0;
        sda_pull     = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(23));
        for (int i = 0; i < 8; i++) begin
            version_table[i] = 16'($urandom());
        end
        model_brightness = reset_brightness;
        model_contrast   = reset_contrast;

        hold_cycles(10);
        rst_n = 1'b1;
        hold_cycles(2 * half_phase);

        check_reset_values();
        reject_other_address();
        write_config_page();
        read_version_wrap();
        read_config_back();

        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/i2c_target_pkg.sv
hdl/regmap_if.sv
hdl/bus_conditioner.sv
hdl/i2c_protocol_fsm.sv
hdl/register_map.sv
hdl/version_i2c_target.sv
sim/i2c_protocol_properties.sv
sim/tb_version_i2c.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_version_i2c
FILELIST  := list.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
